// File: src/prf_pkg.sv
// Physical register file types
package prf_pkg;

   // Datapath width
   localparam int DW = 32;

   // Physical register index width
   localparam int PRF_AW = 5;

   // Physical registers in the file
   localparam int PRF_DEPTH = 32;

   // Writeback lanes into the register file
   localparam int WW = 2;

   // One data word
   typedef logic [DW-1:0] word_t;

   // Physical register index
   typedef logic [PRF_AW-1:0] preg_t;

   // One writeback into the register file
   typedef struct packed {
      // Write strobe
      logic  we;
      // Destination register
      preg_t waddr;
      // Result value
      word_t wdata;
   } wb_req_t;

endpackage

// File: src/lsu_pkg.sv
// Load and store unit types
package lsu_pkg;

   import prf_pkg::*;

   // Byte address width, 64 words
   localparam int DMEM_AW = 8;

   // Wait cycles before the memory read
   localparam int LSU_LAT_CYCLES = 3;

   // Byte address into data memory
   typedef logic [DMEM_AW-1:0] daddr_t;

   // Latency down-counter
   typedef logic [1:0] lat_cnt_t;

   // Access size of a load
   typedef enum logic [1:0] {
      LD_BYTE,
      LD_HALF,
      LD_WORD
   } ld_size_e;

   // Load unit sequence
   typedef enum logic [1:0] {
      LSU_IDLE,
      LSU_WAIT,
      LSU_READ,
      LSU_WB
   } lsu_state_e;

   // One load request
   typedef struct packed {
      logic     valid;
      daddr_t   addr;
      ld_size_e size;
      // Sign extend when set
      logic     sext;
      preg_t    dst;
   } ld_req_t;

   // One whole-word store
   typedef struct packed {
      logic   valid;
      // Word aligned
      daddr_t addr;
      word_t  data;
   } st_req_t;

endpackage

// File: src/wb_mux.sv
// Writeback lane arbiter
`timescale 1ns/1ps

module wb_mux
   import prf_pkg::*;
(
   // Results from the execute lanes
   input  wb_req_t [WW-1:0] ex_wb,
   // Result from the load unit
   input  wb_req_t          lsu_wb,
   // Ready levels from the ROB
   input  logic    [WW-1:0] rob_ready,
   // Ready levels back to the execute lanes
   output logic    [WW-1:0] wb_ready,
   // Merged write ports of the register file
   output wb_req_t [WW-1:0] prf_wr
);

   // Lane 0 is shared between execute and load unit
   // Load unit always has priority
   always_comb
   begin
      if (lsu_wb.we)
      begin
         prf_wr[0] = lsu_wb;
      end
      else
      begin
         prf_wr[0] = ex_wb[0];
      end

      // Displaced execute result must be held and retried
      wb_ready[0] = rob_ready[0] & ~lsu_wb.we;

      // Remaining lanes pass straight through
      for (int i = 1; i < WW; i++)
      begin
         prf_wr[i]   = ex_wb[i];
         wb_ready[i] = rob_ready[i];
      end
   end

   // Execute lane 0 sees back-pressure in every load writeback cycle
   always_comb
   begin
      a_lane0_blocked : assert final (!(lsu_wb.we && wb_ready[0]))
         else $error("wb_mux: lane 0 ready during load writeback");
   end

endmodule

// File: src/prf.sv
// Physical register file
`timescale 1ns/1ps

module prf
   import prf_pkg::*;
(
   input  logic             clk,
   input  logic             rst_n,
   // Write ports, one per writeback lane
   input  wb_req_t [WW-1:0] wr,
   // Read addresses
   input  preg_t   [1:0]    rd_addr,
   // Read results
   output word_t   [1:0]    rd_data
);

   // Register array
   word_t regs [PRF_DEPTH];

   // Both lanes write at the rising edge
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         for (int r = 0; r < PRF_DEPTH; r++)
         begin
            regs[r] <= '0;
         end
      end
      else
      begin
         for (int l = 0; l < WW; l++)
         begin
            if (wr[l].we)
            begin
               regs[wr[l].waddr] <= wr[l].wdata;
            end
         end
      end
   end

   // Combinational reads
   // New value appears only after the write edge
   always_comb
   begin
      for (int p = 0; p < 2; p++)
      begin
         rd_data[p] = regs[rd_addr[p]];
      end
   end

   // Renamer never hands one register to two lanes at once
   // Load unit on lane 0 is covered too
   a_no_dup_write : assert property (
      @(posedge clk) disable iff (!rst_n)
      (wr[0].we && wr[1].we) |-> (wr[0].waddr != wr[1].waddr)
   )
      else $error("prf: both lanes write register %0d", wr[0].waddr);

endmodule

// File: src/lsu_timer.sv
// Memory latency timer
`timescale 1ns/1ps

module lsu_timer
   import lsu_pkg::*;
(
   input  logic clk,
   input  logic rst_n,
   // Load the count
   input  logic start,
   // Count reached zero
   output logic done
);

   lat_cnt_t cnt;
   // Set while a count is active
   logic     run;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         cnt <= '0;
         run <= 1'b0;
      end
      else if (start)
      begin
         // Zero is reached after LSU_LAT_CYCLES cycles
         cnt <= lat_cnt_t'(LSU_LAT_CYCLES - 1);
         run <= 1'b1;
      end
      else if (run)
      begin
         if (cnt == '0)
         begin
            run <= 1'b0;
         end
         else
         begin
            cnt <= cnt - 1'b1;
         end
      end
   end

   // Only a started count flags expiry
   assign done = run && (cnt == '0);

   // Sequencer restarts only after expiry
   a_no_restart : assert property (
      @(posedge clk) disable iff (!rst_n)
      start |-> !run
   )
      else $error("lsu_timer: start while counting");

endmodule

// File: src/lsu_dmem.sv
// Data memory with load alignment
`timescale 1ns/1ps

module lsu_dmem
   import prf_pkg::*;
   import lsu_pkg::*;
(
   input  logic    clk,
   input  logic    rst_n,
   // Whole-word store
   input  st_req_t st,
   // Load read strobe
   input  logic    rd_en,
   // Latched load request
   input  ld_req_t ld,
   // Aligned and extended load value
   output word_t   rd_data
);

   // Word array, index drops the byte offset
   word_t       mem [2**(DMEM_AW-2)];
   word_t       word_sel;
   logic [7:0]  byte_sel;
   logic [15:0] half_sel;
   word_t       ld_val;

   // Store writes at the edge that samples it
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         for (int w = 0; w < 2**(DMEM_AW-2); w++)
         begin
            mem[w] <= '0;
         end
      end
      else if (st.valid)
      begin
         mem[st.addr[DMEM_AW-1:2]] <= st.data;
      end
   end

   // Byte or halfword picked by the low address bits
   always_comb
   begin
      word_sel = mem[ld.addr[DMEM_AW-1:2]];
      byte_sel = word_sel[{ld.addr[1:0], 3'b000} +: 8];
      half_sel = word_sel[{ld.addr[1], 4'b0000} +: 16];
      case (ld.size)
         LD_BYTE: ld_val = {{(DW-8){ld.sext & byte_sel[7]}}, byte_sel};
         LD_HALF: ld_val = {{(DW-16){ld.sext & half_sel[15]}}, half_sel};
         default: ld_val = word_sel;
      endcase
   end

   // Result ready the cycle after the strobe
   always_ff @(posedge clk)
   begin
      if (rd_en)
      begin
         rd_data <= ld_val;
      end
   end

   // Loads naturally aligned
   a_ld_align : assert property (
      @(posedge clk) disable iff (!rst_n)
      rd_en |-> !((ld.size == LD_HALF) && ld.addr[0])
             && !((ld.size == LD_WORD) && (ld.addr[1:0] != 2'b00))
   )
      else $error("lsu_dmem: misaligned load at %0h", ld.addr);

   // Stores are whole words
   a_st_align : assert property (
      @(posedge clk) disable iff (!rst_n)
      st.valid |-> (st.addr[1:0] == 2'b00)
   )
      else $error("lsu_dmem: misaligned store at %0h", st.addr);

endmodule

// File: src/lsu_fsm.sv
// Load unit sequencer
`timescale 1ns/1ps

module lsu_fsm
   import prf_pkg::*;
   import lsu_pkg::*;
(
   input  logic    clk,
   input  logic    rst_n,
   // Request from issue, one-cycle strobe
   input  ld_req_t ld_req,
   // Latency expired
   input  logic    tmr_done,
   // Loaded word, one cycle after the read strobe
   input  word_t   mem_data,
   // Starts the latency count
   output logic    tmr_start,
   // Memory read strobe
   output logic    mem_rd,
   // Latched request to the memory
   output ld_req_t mem_ld,
   // Writeback toward the mux
   output wb_req_t lsu_wb,
   // High while a load is in flight
   output logic    busy
);

   lsu_state_e state;
   lsu_state_e state_nxt;
   ld_req_t    req_q;
   logic       accept;

   // Request taken only in idle
   assign accept = (state == LSU_IDLE) && ld_req.valid;

   // Idle, wait, read, writeback
   always_comb
   begin
      state_nxt = state;
      case (state)
         LSU_IDLE:
         begin
            if (accept)
            begin
               state_nxt = LSU_WAIT;
            end
         end
         LSU_WAIT:
         begin
            if (tmr_done)
            begin
               state_nxt = LSU_READ;
            end
         end
         // Memory result is registered during this cycle
         LSU_READ: state_nxt = LSU_WB;
         LSU_WB:   state_nxt = LSU_IDLE;
         default:  state_nxt = LSU_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state <= LSU_IDLE;
      end
      else
      begin
         state <= state_nxt;
      end
   end

   // Request held for the whole sequence
   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         req_q <= ld_req;
      end
   end

   assign tmr_start = accept;
   assign mem_rd    = (state == LSU_READ);
   assign mem_ld    = req_q;
   assign busy      = (state != LSU_IDLE);

   // Loaded word goes to the latched destination
   assign lsu_wb.we    = (state == LSU_WB);
   assign lsu_wb.waddr = req_q.dst;
   assign lsu_wb.wdata = mem_data;

   // Issue must hold loads while the unit is busy
   a_no_req_busy : assert property (
      @(posedge clk) disable iff (!rst_n)
      ld_req.valid |-> !busy
   )
      else $error("lsu_fsm: load request while busy");

endmodule

// File: src/wb_subsys.sv
// Writeback subsystem top level
`timescale 1ns/1ps

module wb_subsys
   import prf_pkg::*;
   import lsu_pkg::*;
(
   input  logic             clk,
   input  logic             rst_n,
   // Execute lane results
   input  wb_req_t [WW-1:0] ex_wb,
   // Ready levels from the ROB
   input  logic    [WW-1:0] rob_ready,
   // Ready levels to the execute lanes
   output logic    [WW-1:0] wb_ready,
   // Load request strobe
   input  ld_req_t          ld_req,
   // Word store into data memory
   input  st_req_t          st_req,
   // Load in flight
   output logic             lsu_busy,
   // Register file read ports
   input  preg_t   [1:0]    rd_addr,
   output word_t   [1:0]    rd_data
);

   // Load unit internals
   logic             tmr_start;
   logic             tmr_done;
   logic             mem_rd;
   ld_req_t          mem_ld;
   word_t            mem_data;
   // Writeback path
   wb_req_t          lsu_wb;
   wb_req_t [WW-1:0] prf_wr;

   lsu_fsm u_lsu_fsm (
      .clk       (clk),
      .rst_n     (rst_n),
      .ld_req    (ld_req),
      .tmr_done  (tmr_done),
      .mem_data  (mem_data),
      .tmr_start (tmr_start),
      .mem_rd    (mem_rd),
      .mem_ld    (mem_ld),
      .lsu_wb    (lsu_wb),
      .busy      (lsu_busy)
   );

   lsu_timer u_lsu_timer (
      .clk   (clk),
      .rst_n (rst_n),
      .start (tmr_start),
      .done  (tmr_done)
   );

   lsu_dmem u_lsu_dmem (
      .clk     (clk),
      .rst_n   (rst_n),
      .st      (st_req),
      .rd_en   (mem_rd),
      .ld      (mem_ld),
      .rd_data (mem_data)
   );

   // Load result merged into lane 0
   wb_mux u_wb_mux (
      .ex_wb     (ex_wb),
      .lsu_wb    (lsu_wb),
      .rob_ready (rob_ready),
      .wb_ready  (wb_ready),
      .prf_wr    (prf_wr)
   );

   prf u_prf (
      .clk     (clk),
      .rst_n   (rst_n),
      .wr      (prf_wr),
      .rd_addr (rd_addr),
      .rd_data (rd_data)
   );

endmodule

// File: sim/tb_wb_subsys.sv
// Writeback subsystem testbench
`timescale 1ns/1ps

module tb_wb_subsys
   import prf_pkg::*;
   import lsu_pkg::*;
();

   // Sampling edge to register update
   localparam int LOAD_EDGES = LSU_LAT_CYCLES + 2;
   localparam int WAIT_LIMIT = 50;

   logic             clk;
   logic             rst_n;
   wb_req_t [WW-1:0] ex_wb;
   logic    [WW-1:0] rob_ready;
   logic    [WW-1:0] wb_ready;
   ld_req_t          ld_req;
   st_req_t          st_req;
   logic             lsu_busy;
   preg_t   [1:0]    rd_addr;
   word_t   [1:0]    rd_data;

   // Shadow state of the reference model
   word_t       shadow_regs [PRF_DEPTH];
   word_t       shadow_mem [64];
   logic [31:0] lfsr;
   int          value_errors;
   int          timeout_errors;

   wb_subsys u_dut (
      .clk       (clk),
      .rst_n     (rst_n),
      .ex_wb     (ex_wb),
      .rob_ready (rob_ready),
      .wb_ready  (wb_ready),
      .ld_req    (ld_req),
      .st_req    (st_req),
      .lsu_busy  (lsu_busy),
      .rd_addr   (rd_addr),
      .rd_data   (rd_data)
   );

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Galois LFSR shifting right
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      if (s[0])
      begin
         return (s >> 1) ^ 32'h8020_0003;
      end
      return s >> 1;
   endfunction

   // One step per bit taken
   task automatic rand_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         v    = {v[30:0], lfsr[0]};
         lfsr = lfsr_next(lfsr);
      end
   endtask

   // Aligned and extended load value from a memory word
   function automatic word_t expect_load(input word_t w, input daddr_t a,
                                         input ld_size_e sz, input logic sx);
      word_t sh;
      sh = w >> (8 * a[1:0]);
      case (sz)
         LD_BYTE: return sx ? {{24{sh[7]}}, sh[7:0]} : {24'h0, sh[7:0]};
         LD_HALF: return sx ? {{16{sh[15]}}, sh[15:0]} : {16'h0, sh[15:0]};
         default: return w;
      endcase
   endfunction

   task automatic check_value(input string name, input word_t exp, input word_t act);
      a_value : assert (act === exp)
      else
      begin
         value_errors++;
         $display("CHECK FAILED t=%0t %s expected %h actual %h", $time, name, exp, act);
      end
   endtask

   // Inputs change 2 ns after the edge
   task automatic next_cycle();
      @(posedge clk);
      #2;
   endtask

   task automatic wait_idle();
      int n;
      n = 0;
      while (lsu_busy && n < WAIT_LIMIT)
      begin
         n++;
         next_cycle();
      end
      if (lsu_busy)
      begin
         timeout_errors++;
         $display("Timeout at %0t: load unit never went idle", $time);
      end
   endtask

   task automatic store_word(input int idx, input word_t data);
      st_req.valid = 1'b1;
      st_req.addr  = daddr_t'(idx * 4);
      st_req.data  = data;
      next_cycle();
      st_req.valid = 1'b0;
      shadow_mem[idx] = data;
   endtask

   // One load followed by busy length and destination checks
   task automatic run_load(input daddr_t a, input ld_size_e sz, input logic sx,
                           input preg_t d);
      int    n;
      word_t exp;
      exp = expect_load(shadow_mem[a[7:2]], a, sz, sx);
      wait_idle();
      ld_req.valid = 1'b1;
      ld_req.addr  = a;
      ld_req.size  = sz;
      ld_req.sext  = sx;
      ld_req.dst   = d;
      next_cycle();
      ld_req.valid = 1'b0;
      n = 0;
      while (lsu_busy && n < WAIT_LIMIT)
      begin
         n++;
         next_cycle();
      end
      if (lsu_busy)
      begin
         timeout_errors++;
         $display("Timeout at %0t: load to p%0d never finished", $time, d);
      end
      check_value("lsu_busy cycles", LOAD_EDGES, n);
      shadow_regs[d] = exp;
      rd_addr[0] = d;
      #1;
      check_value("rd_data[0]", exp, rd_data[0]);
   endtask

   // Execute lane 0 busy in every cycle of a word load
   task automatic load_under_traffic();
      logic [31:0] r;
      preg_t       d;
      preg_t       e;
      preg_t       t;
      daddr_t      a;
      word_t       exp;
      rand_bits(8, r);
      a = daddr_t'(r) & 8'hfc;
      rand_bits(5, r);
      d = r[4:0];
      rand_bits(5, r);
      e = r[4:0];
      if (e == d)
      begin
         e = d ^ 5'd1;
      end
      exp = shadow_mem[a[7:2]];
      wait_idle();
      rob_ready    = 2'b11;
      ld_req.valid = 1'b1;
      ld_req.addr  = a;
      ld_req.size  = LD_WORD;
      ld_req.sext  = 1'b0;
      ld_req.dst   = d;
      next_cycle();
      ld_req.valid = 1'b0;
      for (int k = 1; k <= LOAD_EDGES; k++)
      begin
         // Last cycle is the load writeback
         rand_bits(5, r);
         t = (k == LOAD_EDGES) ? e : r[4:0];
         while (k != LOAD_EDGES && (t == d || t == e))
         begin
            t = t + 1'b1;
         end
         rand_bits(32, r);
         ex_wb[0].we    = 1'b1;
         ex_wb[0].waddr = t;
         ex_wb[0].wdata = r;
         #1;
         check_value("wb_ready[0]", (k != LOAD_EDGES), wb_ready[0]);
         if (k != LOAD_EDGES)
         begin
            shadow_regs[t] = r;
         end
         next_cycle();
      end
      ex_wb[0].we = 1'b0;
      shadow_regs[d] = exp;
      rd_addr[0] = d;
      rd_addr[1] = e;
      #1;
      check_value("rd_data[0]", exp, rd_data[0]);
      // Displaced write left no trace
      check_value("rd_data[1]", shadow_regs[e], rd_data[1]);
   endtask

   initial
   begin
      logic [31:0] r;
      logic [31:0] r2;
      preg_t       a0;
      preg_t       a1;
      daddr_t      la;
      lfsr           = 32'h58c3;
      value_errors   = 0;
      timeout_errors = 0;
      rst_n     = 1'b0;
      ex_wb     = '0;
      rob_ready = '0;
      ld_req    = '0;
      st_req    = '0;
      rd_addr   = '0;
      for (int i = 0; i < PRF_DEPTH; i++)
      begin
         shadow_regs[i] = '0;
      end
      for (int i = 0; i < 64; i++)
      begin
         shadow_mem[i] = '0;
      end
      repeat (5) @(posedge clk);
      #2;
      rst_n = 1'b1;

      // Idle after reset and all registers zero
      check_value("lsu_busy", 1'b0, lsu_busy);
      for (int i = 0; i < PRF_DEPTH / 2; i++)
      begin
         rd_addr[0] = preg_t'(i);
         rd_addr[1] = preg_t'(PRF_DEPTH - 1 - i);
         #1;
         check_value("rd_data[0]", '0, rd_data[0]);
         check_value("rd_data[1]", '0, rd_data[1]);
         next_cycle();
      end
      for (int i = 0; i < 4; i++)
      begin
         rob_ready = i[1:0];
         #1;
         check_value("wb_ready", rob_ready, wb_ready);
         next_cycle();
      end

      // Both lanes to distinct registers
      rob_ready = 2'b11;
      for (int i = 0; i < 20; i++)
      begin
         rand_bits(5, r);
         a0 = r[4:0];
         rand_bits(5, r);
         a1 = (r[4:0] == a0) ? (a0 ^ 5'd1) : r[4:0];
         rand_bits(32, r);
         rand_bits(32, r2);
         ex_wb[0].we    = 1'b1;
         ex_wb[0].waddr = a0;
         ex_wb[0].wdata = r;
         ex_wb[1].we    = 1'b1;
         ex_wb[1].waddr = a1;
         ex_wb[1].wdata = r2;
         next_cycle();
         ex_wb[0].we = 1'b0;
         ex_wb[1].we = 1'b0;
         shadow_regs[a0] = r;
         shadow_regs[a1] = r2;
         rd_addr[0] = a0;
         rd_addr[1] = a1;
         #1;
         check_value("rd_data[0]", shadow_regs[a0], rd_data[0]);
         check_value("rd_data[1]", shadow_regs[a1], rd_data[1]);
         next_cycle();
      end

      // Ready pass-through with no load pending
      for (int i = 0; i < 8; i++)
      begin
         next_cycle();
         rand_bits(2, r);
         rob_ready = r[1:0];
         #1;
         check_value("wb_ready[0]", rob_ready[0], wb_ready[0]);
         check_value("wb_ready[1]", rob_ready[1], wb_ready[1]);
      end

      // Fill memory and then load every size and extension
      next_cycle();
      for (int i = 0; i < 64; i++)
      begin
         rand_bits(32, r);
         store_word(i, r);
      end
      for (int sz = 0; sz < 3; sz++)
      begin
         for (int sx = 0; sx < 2; sx++)
         begin
            for (int j = 0; j < 4; j++)
            begin
               rand_bits(8, r);
               la = daddr_t'(r);
               if (sz == 1)
               begin
                  la[0] = 1'b0;
               end
               else if (sz == 2)
               begin
                  la[1:0] = 2'b00;
               end
               rand_bits(5, r);
               next_cycle();
               run_load(la, ld_size_e'(sz), sx[0], r[4:0]);
            end
         end
      end

      // Lane 0 contention
      next_cycle();
      load_under_traffic();
      next_cycle();

      $display("Errors: %0d value, %0d timeout", value_errors, timeout_errors);
      if (value_errors == 0 && timeout_errors == 0)
      begin
         $display("Everything OK");
      end
      else
      begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

// File: wb_subsys.f
src/prf_pkg.sv
src/lsu_pkg.sv
src/wb_mux.sv
src/prf.sv
src/lsu_timer.sv
src/lsu_dmem.sv
src/lsu_fsm.sv
src/wb_subsys.sv
sim/tb_wb_subsys.sv

// File: Bender.yml
package:
  name: wb_subsys

sources:
  - files:
      - src/prf_pkg.sv
      - src/lsu_pkg.sv
      - src/wb_mux.sv
      - src/prf.sv
      - src/lsu_timer.sv
      - src/lsu_dmem.sv
      - src/lsu_fsm.sv
      - src/wb_subsys.sv
  - target: simulation
    files:
      - sim/tb_wb_subsys.sv
